//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes and function codes of RV32I.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] funct7_alt = 7'b0100000; // Marks SUB and SRA/SRAI.

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction formats, all overlaid on the same word.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } instr_u;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [1:0] {
        src_a_rs1  = 2'd0,
        src_a_pc   = 2'd1,
        src_a_zero = 2'd2
    } alu_src_a_e;

    typedef enum logic [1:0] {
        src_b_rs2 = 2'd0,
        src_b_imm = 2'd1
    } alu_src_b_e;

    typedef enum logic [1:0] {
        wb_alu       = 2'd0,
        wb_pc_plus_4 = 2'd1
    } wb_select_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded control and the ID/EX payload.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic       jump;      // JAL or JALR.
        logic       jalr;
        logic       branch;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        alu_src_a_e alu_src_a;
        alu_src_b_e alu_src_b;
        alu_op_e    alu_op;
        wb_select_e wb_select;
        logic [2:0] funct3;    // Branch condition lives here too.
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic            valid;  // Zero means bubble.
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus_4;
        logic            branch_estimation;
        ctrl_t           ctrl;
        logic [xlen-1:0] read_data1;
        logic [xlen-1:0] read_data2;
        logic [xlen-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic            enable;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

endpackage

//--- logic/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  rv_isa_pkg::instr_u          instr,
    input  logic                        instr_valid,
    output pipe_pkg::ctrl_t             ctrl,
    output logic [rv_isa_pkg::xlen-1:0] imm,
    output logic                        valid
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic legal;
    logic alt;

    // Register ops may subtract; immediate ops only use the marker for SRAI.
    function automatic alu_op_e alu_decode(
        input logic [2:0] funct3,
        input logic       alt_op,
        input logic       reg_op
    );
        alu_op_e op;
        case (funct3)
            f3_add_sub: op = (alt_op && reg_op) ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt_op ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
        endcase
        return op;
    endfunction

    assign alt = (instr.r_type.funct7 == funct7_alt);

    always_comb begin
        legal          = 1'b1;
        imm            = '0;
        ctrl           = '0;
        ctrl.alu_src_a = src_a_rs1;
        ctrl.alu_src_b = src_b_rs2;
        ctrl.alu_op    = alu_add;
        ctrl.wb_select = wb_alu;
        ctrl.funct3    = instr.r_type.funct3;
        ctrl.rd        = instr.r_type.rd;

        case (instr.r_type.opcode)
            opc_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(instr.r_type.funct3, alt, 1'b1);
            end
            opc_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_b = src_b_imm;
                ctrl.alu_op    = alu_decode(instr.r_type.funct3, alt, 1'b0);
                imm = {{20{instr.i_type.imm_11_0[11]}}, instr.i_type.imm_11_0};
            end
            opc_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_a = src_a_zero;
                ctrl.alu_src_b = src_b_imm;
                ctrl.alu_op    = alu_pass_b;
                imm = {instr.u_type.imm_31_12, 12'b0};
            end
            opc_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_a = src_a_pc;
                ctrl.alu_src_b = src_b_imm;
                imm = {instr.u_type.imm_31_12, 12'b0};
            end
            opc_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_select = wb_pc_plus_4;
                ctrl.alu_src_a = src_a_pc;
                ctrl.alu_src_b = src_b_imm;
                imm = {{11{instr.j_type.imm_20}}, instr.j_type.imm_20,
                       instr.j_type.imm_19_12, instr.j_type.imm_11,
                       instr.j_type.imm_10_1, 1'b0};
            end
            opc_jalr: begin
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_select = wb_pc_plus_4;
                ctrl.alu_src_b = src_b_imm;
                imm = {{20{instr.i_type.imm_11_0[11]}}, instr.i_type.imm_11_0};
            end
            opc_branch: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
                ctrl.rd     = 5'd0;
                imm = {{19{instr.b_type.imm_12}}, instr.b_type.imm_12,
                       instr.b_type.imm_11, instr.b_type.imm_10_5,
                       instr.b_type.imm_4_1, 1'b0};
            end
            opc_load: begin
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src_b = src_b_imm;
                imm = {{20{instr.i_type.imm_11_0[11]}}, instr.i_type.imm_11_0};
            end
            opc_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src_b = src_b_imm;
                ctrl.rd        = 5'd0;
                imm = {{20{instr.s_type.imm_11_5[6]}}, instr.s_type.imm_11_5,
                       instr.s_type.imm_4_0};
            end
            default: begin
                legal = 1'b0;  // Unknown opcode goes down the pipe as a bubble.
                ctrl  = '0;
            end
        endcase
    end

    assign valid = instr_valid & legal;

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    output logic [rv_isa_pkg::xlen-1:0] read_data1,
    output logic [rv_isa_pkg::xlen-1:0] read_data2,
    input  pipe_pkg::wb_t               wb
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] regs [1:31];  // x0 has no storage.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Forward a write-back landing this cycle so ID sees it immediately.
    function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wb.enable && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        read_data1 = read_port(rs1);
    end

    always_comb begin
        read_data2 = read_port(rs2);
    end

endmodule

//--- logic/id_ex_register.sv
`timescale 1ns/1ns

module id_ex_register (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  pipe_pkg::id_ex_t id,
    output pipe_pkg::id_ex_t ex
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // All-zero contents are a bubble since valid is cleared with the rest.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex <= '0;
        end else if (flush) begin
            ex <= '0;  // Kill the wrong-path instruction behind a redirect.
        end else begin
            ex <= id;
        end
    end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  pipe_pkg::id_ex_t            ex,
    output pipe_pkg::wb_t               wb,
    output logic [rv_isa_pkg::xlen-1:0] result,
    output logic [rv_isa_pkg::xlen-1:0] store_data,
    output logic                        redirect,
    output logic [rv_isa_pkg::xlen-1:0] redirect_pc
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_out;
    logic            cond;
    logic            taken;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] target;
    logic [xlen-1:0] wb_data;

    always_comb begin
        case (ex.ctrl.alu_src_a)
            src_a_pc:   op_a = ex.pc;
            src_a_zero: op_a = '0;
            default:    op_a = ex.read_data1;
        endcase
        op_b = (ex.ctrl.alu_src_b == src_b_imm) ? ex.imm : ex.read_data2;
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.ctrl.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $signed(op_a) >>> shamt;
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // Branch condition always compares the two register operands.
    always_comb begin
        case (ex.ctrl.funct3)
            f3_beq:  cond = (ex.read_data1 == ex.read_data2);
            f3_bne:  cond = (ex.read_data1 != ex.read_data2);
            f3_blt:  cond = ($signed(ex.read_data1) < $signed(ex.read_data2));
            f3_bge:  cond = ($signed(ex.read_data1) >= $signed(ex.read_data2));
            f3_bltu: cond = (ex.read_data1 < ex.read_data2);
            f3_bgeu: cond = (ex.read_data1 >= ex.read_data2);
            default: cond = 1'b0;
        endcase
    end

    assign jalr_sum = ex.read_data1 + ex.imm;
    assign target   = ex.ctrl.jalr ? {jalr_sum[xlen-1:1], 1'b0} : ex.pc + ex.imm;
    assign taken    = ex.ctrl.jump | (ex.ctrl.branch & cond);

    // Jumps always redirect; the front end is outside this slice.
    assign redirect = ex.valid &
                      (ex.ctrl.jump | (ex.ctrl.branch & (cond != ex.branch_estimation)));
    assign redirect_pc = taken ? target : ex.pc_plus_4;

    assign wb_data    = (ex.ctrl.wb_select == wb_pc_plus_4) ? ex.pc_plus_4 : alu_out;
    assign wb.enable  = ex.valid & ex.ctrl.reg_write;  // Loads never write back here.
    assign wb.rd      = ex.ctrl.rd;
    assign wb.data    = wb_data;
    assign result     = wb_data;
    assign store_data = ex.read_data2;

endmodule

//--- logic/decode_execute_top.sv
`timescale 1ns/1ns

module decode_execute_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    input  logic [rv_isa_pkg::xlen-1:0] pc,
    input  logic                        branch_estimation,
    output logic                        ex_valid,
    output logic [rv_isa_pkg::xlen-1:0] ex_result,
    output logic [4:0]                  ex_rd,
    output logic                        ex_mem_read,
    output logic                        ex_mem_write,
    output logic [rv_isa_pkg::xlen-1:0] ex_store_data,
    output logic                        redirect,
    output logic [rv_isa_pkg::xlen-1:0] redirect_pc
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    instr_u          instr_word;
    ctrl_t           id_ctrl;
    logic [xlen-1:0] id_imm;
    logic            id_valid;
    logic [xlen-1:0] read_data1;
    logic [xlen-1:0] read_data2;
    id_ex_t          id_stage;
    id_ex_t          ex_stage;
    wb_t             wb;
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;

    assign instr_word = instr;

    register_file u_register_file (
        .clk        (clk),
        .reset      (reset),
        .rs1        (instr_word.r_type.rs1),
        .rs2        (instr_word.r_type.rs2),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .wb         (wb)
    );

    instr_decoder u_instr_decoder (
        .instr       (instr_word),
        .instr_valid (instr_valid),
        .ctrl        (id_ctrl),
        .imm         (id_imm),
        .valid       (id_valid)
    );

    assign id_stage = '{valid: id_valid, pc: pc, pc_plus_4: pc + 32'd4,
                        branch_estimation: branch_estimation, ctrl: id_ctrl,
                        read_data1: read_data1, read_data2: read_data2, imm: id_imm};

    id_ex_register u_id_ex_register (
        .clk   (clk),
        .reset (reset),
        .flush (redirect),
        .id    (id_stage),
        .ex    (ex_stage)
    );

    execute_unit u_execute_unit (
        .ex          (ex_stage),
        .wb          (wb),
        .result      (result),
        .store_data  (store_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX stage outputs, quiet while a bubble sits in the register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ex_valid      = ex_stage.valid;
    assign ex_result     = ex_stage.valid ? result : '0;
    assign ex_rd         = ex_stage.valid ? ex_stage.ctrl.rd : 5'd0;
    assign ex_mem_read   = ex_stage.valid & ex_stage.ctrl.mem_read;
    assign ex_mem_write  = ex_stage.valid & ex_stage.ctrl.mem_write;
    assign ex_store_data = ex_stage.valid ? store_data : '0;

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;  // 20 ns period.
        end
    end

endmodule

//--- verification/decode_execute_chk.sv
`timescale 1ns/1ns

module decode_execute_chk (
    input logic                        clk,
    input logic                        reset,
    input logic                        ex_valid,
    input logic                        redirect,
    input logic                        ex_mem_read,
    input logic                        ex_mem_write,
    input logic [rv_isa_pkg::xlen-1:0] redirect_pc
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline invariants seen at the top level ports.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    quiet_in_reset: assert property (@(posedge clk) reset |-> !ex_valid)
        else $error("ex_valid is high while reset is asserted");

    bubble_after_redirect: assert property (
        @(posedge clk) disable iff (reset) redirect |=> !ex_valid)
        else $error("the instruction behind a redirect was not flushed");

    redirect_needs_valid: assert property (@(posedge clk) redirect |-> ex_valid)
        else $error("redirect is high without a valid EX instruction");

    single_mem_strobe: assert property (@(posedge clk) !(ex_mem_read && ex_mem_write))
        else $error("load and store strobes are high together");

    aligned_target: assert property (@(posedge clk) redirect |-> redirect_pc[1:0] == 2'b00)
        else $error("redirect_pc is not 4-byte aligned");

endmodule

//--- verification/decode_execute_tb.sv
`timescale 1ns/1ns

module decode_execute_tb;
    import rv_isa_pkg::*;

    typedef struct packed {
        logic        instr_valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        branch_estimation;
        logic        ex_valid;       // Expected values for the row above start here.
        logic [31:0] ex_result;
        logic [4:0]  ex_rd;
        logic        ex_mem_read;
        logic        ex_mem_write;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic [31:0] ex_store_data;
    } vector_t;

    localparam int    reset_cycles = 16;
    localparam int    slack_cycles = 40;
    localparam string vector_file  = "verification/decode_execute_vectors.txt";

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        branch_estimation;
    logic        ex_valid;
    logic [31:0] ex_result;
    logic [4:0]  ex_rd;
    logic        ex_mem_read;
    logic        ex_mem_write;
    logic [31:0] ex_store_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    vector_t vectors[$];
    string   names[$];
    int      cycle_count  = 0;
    int      cycle_limit  = reset_cycles + slack_cycles;
    int      error_count  = 0;
    int      test_errors  = 0;
    int      test_lines   = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    logic    prev_branch  = 1'b0;

    tb_clock u_clock (
        .clk (clk)
    );

    decode_execute_top dut (
        .clk               (clk),
        .reset             (reset),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .pc                (pc),
        .branch_estimation (branch_estimation),
        .ex_valid          (ex_valid),
        .ex_result         (ex_result),
        .ex_rd             (ex_rd),
        .ex_mem_read       (ex_mem_read),
        .ex_mem_write      (ex_mem_write),
        .ex_store_data     (ex_store_data),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc)
    );

    bind decode_execute_top decode_execute_chk chk (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .redirect     (redirect),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write),
        .redirect_pc  (redirect_pc)
    );

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        string       name;
        logic [31:0] f [12];
        vector_t     v;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %0s.", vector_file);
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", name,
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                    f[8], f[9], f[10], f[11]);
                    if (count == 13) begin
                        v = '{f[0][0], f[1], f[2], f[3][0], f[4][0], f[5], f[6][4:0],
                              f[7][0], f[8][0], f[9][0], f[10], f[11]};
                        vectors.push_back(v);
                        names.push_back(name);
                    end else begin
                        $display("A vector line could not be read: %0s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED at %0t ns: %0s is %h, expected %h", $time, field, got, expected);
        error_count++;
        test_errors++;
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0s: pass (%0d vectors)", name, test_lines);
        end else begin
            tests_failed++;
            $display("test %0s: fail (%0d vectors, %0d errors)", name, test_lines, test_errors);
        end
        test_errors = 0;
        test_lines  = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Each row drives one cycle and checks the instruction of the row above.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        vector_t v;
        string   current;
        reset             = 1'b1;
        instr_valid       = 1'b0;
        instr             = '0;
        pc                = '0;
        branch_estimation = 1'b0;
        load_vectors();
        if (vectors.size() == 0) begin
            $display("The vector file is missing or holds no vectors.");
            $display("TEST FAILED");
        end else begin
            cycle_limit = reset_cycles + vectors.size() + slack_cycles;
            repeat (reset_cycles) @(posedge clk);
            #2;
            reset   = 1'b0;
            current = names[0];
            foreach (vectors[i]) begin
                v = vectors[i];
                if (i > 0) begin
                    @(posedge clk);
                    #2;
                end
                if (names[i] != current) begin
                    close_test(current);
                    current = names[i];
                end
                instr_valid       = v.instr_valid;
                instr             = v.instr;
                pc                = v.pc;
                branch_estimation = v.branch_estimation;
                #16;  // Just before the next edge.
                if (ex_valid !== v.ex_valid) report_mismatch("ex_valid", ex_valid, v.ex_valid);
                if (!prev_branch && ex_result !== v.ex_result) begin
                    report_mismatch("ex_result", ex_result, v.ex_result);
                end
                if (ex_rd !== v.ex_rd) report_mismatch("ex_rd", ex_rd, v.ex_rd);
                if (ex_mem_read !== v.ex_mem_read) begin
                    report_mismatch("ex_mem_read", ex_mem_read, v.ex_mem_read);
                end
                if (ex_mem_write !== v.ex_mem_write) begin
                    report_mismatch("ex_mem_write", ex_mem_write, v.ex_mem_write);
                end
                if (redirect !== v.redirect) report_mismatch("redirect", redirect, v.redirect);
                if (v.redirect && redirect_pc !== v.redirect_pc) begin
                    report_mismatch("redirect_pc", redirect_pc, v.redirect_pc);
                end
                if (v.ex_mem_write && ex_store_data !== v.ex_store_data) begin
                    report_mismatch("ex_store_data", ex_store_data, v.ex_store_data);
                end
                prev_branch = v.instr_valid && (v.instr[6:0] == opc_branch);  // No result.
                test_lines++;
            end
            close_test(current);
            $display("Tests passed: %0d, failed: %0d, vectors: %0d, errors: %0d",
                     tests_passed, tests_failed, vectors.size(), error_count);
            if (error_count == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("The run did not finish within %0d cycles.", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

//--- verification/decode_execute_vectors.txt
# test iv instr pc be | then expected for the row above:
# ev result rd mem_read mem_write redirect redirect_pc store_data
reset  0 00000013 00000100 0  0 00000000 00 0 0 0 00000000 00000000
alu    1 00500093 00000104 0  0 00000000 00 0 0 0 00000000 00000000
alu    1 FFD00113 00000108 0  1 00000005 01 0 0 0 00000000 00000000
alu    1 002081B3 0000010C 0  1 FFFFFFFD 02 0 0 0 00000000 00000000
alu    1 40208233 00000110 0  1 00000002 03 0 0 0 00000000 00000000
alu    1 001092B3 00000114 0  1 00000008 04 0 0 0 00000000 00000000
alu    1 00112333 00000118 0  1 000000A0 05 0 0 0 00000000 00000000
alu    1 001133B3 0000011C 0  1 00000001 06 0 0 0 00000000 00000000
alu    1 40115413 00000120 0  1 00000000 07 0 0 0 00000000 00000000
alu    1 01C15493 00000124 0  1 FFFFFFFE 08 0 0 0 00000000 00000000
alu    1 0FF0C513 00000128 0  1 0000000F 09 0 0 0 00000000 00000000
alu    1 0020E5B3 0000012C 0  1 000000FA 0A 0 0 0 00000000 00000000
alu    1 00F17613 00000130 0  1 FFFFFFFD 0B 0 0 0 00000000 00000000
alu    1 123456B7 00000134 0  1 0000000D 0C 0 0 0 00000000 00000000
alu    1 00001717 00000138 0  1 12345000 0D 0 0 0 00000000 00000000
bypass 1 00700013 0000013C 0  1 00001138 0E 0 0 0 00000000 00000000
bypass 1 00100793 00000140 0  1 00000007 00 0 0 0 00000000 00000000
bypass 1 00F78833 00000144 0  1 00000001 0F 0 0 0 00000000 00000000
branch 1 00108463 00000148 1  1 00000002 10 0 0 0 00000000 00000000
branch 1 00114863 0000014C 0  1 00000000 00 0 0 0 00000000 00000000
branch 1 06300093 00000150 0  1 00000000 00 0 0 1 0000015C 00000000
branch 1 00109463 0000015C 1  0 00000000 00 0 0 0 00000000 00000000
branch 1 00100A93 00000160 0  1 00000000 00 0 0 1 00000160 00000000
branch 1 00117463 00000164 1  0 00000000 00 0 0 0 00000000 00000000
branch 1 01508833 00000168 0  1 00000000 00 0 0 0 00000000 00000000
jump   1 020008EF 0000016C 0  1 00000005 10 0 0 0 00000000 00000000
jump   1 06300093 00000170 0  1 00000170 11 0 0 1 0000018C 00000000
jump   1 00008967 0000018C 0  0 00000000 00 0 0 0 00000000 00000000
jump   1 06300093 00000190 0  1 00000190 12 0 0 1 00000004 00000000
memory 1 01108223 00000194 0  0 00000000 00 0 0 0 00000000 00000000
memory 1 01212023 00000198 0  1 00000009 00 0 1 0 00000000 00000170
memory 1 FFC12983 0000019C 0  1 FFFFFFFD 00 0 1 0 00000000 00000190
memory 1 00098A33 000001A0 0  1 FFFFFFF9 13 1 0 0 00000000 00000000
bubble 1 FFFFFFFF 000001A4 0  1 00000000 14 0 0 0 00000000 00000000
bubble 0 00100B13 000001A8 0  0 00000000 00 0 0 0 00000000 00000000
bubble 1 000B0BB3 000001AC 0  0 00000000 00 0 0 0 00000000 00000000
bubble 0 00000013 000001B0 0  1 00000000 17 0 0 0 00000000 00000000

//--- project.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/id_ex_register.sv
logic/execute_unit.sv
logic/decode_execute_top.sv
verification/tb_clock.sv
verification/decode_execute_chk.sv
verification/decode_execute_tb.sv

//--- Bender.yml
package:
  name: decode_execute

sources:
  - logic/rv_isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/instr_decoder.sv
  - logic/register_file.sv
  - logic/id_ex_register.sv
  - logic/execute_unit.sv
  - logic/decode_execute_top.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/decode_execute_chk.sv
      - verification/decode_execute_tb.sv
